// File: list.f
+incdir+include
logic/term_geom_pkg.sv
logic/term_char_pkg.sv
logic/cursor_ctrl.sv
logic/scan_timing.sv
logic/char_store.sv
logic/pixel_compose.sv
logic/text_term.sv
tb/tb_text_term.sv

// File: Makefile
# Verilator flow for the text terminal
VERILATOR  ?= verilator
TB_TOP     ?= tb_text_term
RTL_TOP    ?= text_term
FILE_LIST  ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL TESTS PASSED
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_text_term.sv
`timescale 1ns/1ns
`default_nettype none

`include "glyph_table.svh"

module tb_text_term;
  import term_geom_pkg::*;
  import term_char_pkg::*;

  localparam int NUM_ROWS   = DEF_NUM_ROWS;
  localparam int NUM_COLS   = DEF_NUM_COLS;
  localparam int H_BLANK    = DEF_H_BLANK;
  localparam int V_BLANK    = DEF_V_BLANK;
  localparam int SYNC_LEN   = DEF_SYNC_LEN;
  localparam int CLK_PERIOD = 8;
  localparam int H_VIS      = NUM_COLS * 8;
  localparam int V_VIS      = NUM_ROWS * 8;
  localparam int H_TOTAL    = H_VIS + H_BLANK;
  localparam int V_TOTAL    = V_VIS + V_BLANK;
  // Four frames before a wait gives up
  localparam int WAIT_LIMIT = 4 * H_TOTAL * V_TOTAL;

  logic        clk = 1'b0;
  logic        rst;
  char_t       ascii;
  logic        ascii_val;
  logic        hsync;
  logic        vsync;
  logic        de;
  logic        pixel;

  // Screen model and cursor state
  char_t       screen [NUM_ROWS][NUM_COLS];
  int          m_row;
  int          m_col;
  int          m_top;
  logic [31:0] rng_state   = 32'h122c_46d2;
  string       hex_chars   = "0123456789ABCDEF ";
  string       test_name   = "reset";
  int          error_count = 0;
  int          check_count = 0;
  int          frames_done = 0;
  logic        timed_out   = 1'b0;

  // Frame checker state
  logic        prev_hs;
  logic        prev_vs;
  logic        prev_de;
  logic        armed;
  logic        had_fall;
  int          pix_idx;
  int          line_pix;
  int          lines;
  int          hs_rises;
  int          hs_len;
  int          vs_len;
  int          frame_cycles;

  text_term #(
    .NUM_ROWS (NUM_ROWS),
    .NUM_COLS (NUM_COLS),
    .H_BLANK  (H_BLANK),
    .V_BLANK  (V_BLANK),
    .SYNC_LEN (SYNC_LEN)
  ) dut (
    .clk       (clk),
    .rst       (rst),
    .ascii     (ascii),
    .ascii_val (ascii_val),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de),
    .pixel     (pixel)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Codes with a real glyph in the font
  function automatic logic is_hex_glyph(input char_t c);
    return (c == 8'h20) || (c >= 8'h30 && c <= 8'h39) || (c >= 8'h41 && c <= 8'h46);
  endfunction

  // Expected bit at a visible pixel position
  function automatic logic ref_pixel(input int x, input int y);
    int         col;
    int         hoff;
    int         voff;
    int         prow;
    logic [7:0] bits;
    col  = x / 8;
    hoff = x % 8;
    voff = y % 8;
    // Display row maps through the scroll offset
    prow = (y / 8 + m_top) % NUM_ROWS;
    if (prow == m_row && col == m_col && voff == 7 && hoff != 7) begin
      return 1'b1;
    end
    bits = glyph_row(screen[prow][col], cell_off_t'(voff));
    return bits[7 - hoff];
  endfunction

  task automatic check_eq(input string name, input int exp, input int act);
    check_count++;
    if (exp != act) begin
      error_count++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_and_finish();
    $display("Summary: %0d errors, %0d checks", error_count, check_count);
    if (!timed_out && error_count == 0 && check_count > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // ----------------------------------------
  // Screen model
  // ----------------------------------------

  task automatic clear_model();
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        screen[r][c] = '0;
      end
    end
    m_row = 0;
    m_col = 0;
    // Cursor row sits on the bottom line
    m_top = 1 % NUM_ROWS;
  endtask

  // Enter and wipe the next row and scroll by one
  task automatic advance_line();
    m_row = (m_row + 1) % NUM_ROWS;
    m_col = 0;
    for (int c = 0; c < NUM_COLS; c++) begin
      screen[m_row][c] = '0;
    end
    m_top = (m_top + 1) % NUM_ROWS;
  endtask

  task automatic apply_to_model(input char_t b);
    if (b == CHAR_ESC) begin
      clear_model();
    end else if (b == CHAR_DEL) begin
      if (m_col > 0) begin
        m_col--;
      end
      screen[m_row][m_col] = '0;
    end else if (b == CHAR_LF) begin
      advance_line();
    end else begin
      screen[m_row][m_col] = b;
      if (m_col == NUM_COLS - 1) begin
        advance_line();
      end else begin
        m_col++;
      end
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  task automatic send_byte(input char_t b);
    if (!timed_out) begin
      ascii     <= b;
      ascii_val <= 1'b1;
      apply_to_model(b);
      @(posedge clk);
    end
  endtask

  task automatic send_text(input string s);
    for (int i = 0; i < s.len(); i++) begin
      send_byte(char_t'(s[i]));
    end
  endtask

  // Random hex glyph or box code
  // Box only on request
  task automatic send_random(input logic box_only);
    char_t c;
    rng_state = xorshift32(rng_state);
    if (!box_only && rng_state[31]) begin
      c = char_t'(hex_chars[int'(rng_state[15:0]) % hex_chars.len()]);
    end else begin
      c = 8'h20;
      while (is_hex_glyph(c)) begin
        rng_state = xorshift32(rng_state);
        c = char_t'(8'h21 + int'(rng_state[15:0]) % 94);
      end
    end
    send_byte(c);
  endtask

  task automatic wait_frame_done(input string what);
    int start;
    int cycles;
    start  = frames_done;
    cycles = 0;
    while (frames_done == start && !timed_out) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("Timeout: no complete frame seen during test %s", what);
        timed_out = 1'b1;
      end
    end
  endtask

  // Idle stream while the next whole frame is compared
  task automatic check_frame(input string name);
    ascii_val <= 1'b0;
    ascii     <= '0;
    test_name  = name;
    wait_frame_done(name);
  endtask

  initial begin
    rst       = 1'b1;
    ascii     = '0;
    ascii_val = 1'b0;
    clear_model();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    check_frame("reset");
    // Every batch lands in vertical blanking
    send_text("0123456");
    check_frame("hex digits");
    send_byte(CHAR_LF);
    send_text("789ABCD");
    check_frame("hex digits next line");
    send_byte(CHAR_LF);
    send_text(" EF");
    repeat (4) send_random(1'b1);
    check_frame("box codes");
    // Wrap past the last column
    repeat (NUM_COLS + 3) send_random(1'b0);
    check_frame("wrap");
    repeat (2 * NUM_COLS + 1) send_random(1'b0);
    send_byte(CHAR_LF);
    check_frame("double wrap and line feed");
    send_byte(CHAR_LF);
    send_byte(CHAR_LF);
    check_frame("line feeds");
    send_text("12");
    send_byte(CHAR_DEL);
    check_frame("delete");
    // Last one hits column 0
    repeat (3) send_byte(CHAR_DEL);
    check_frame("delete at column 0");
    send_text("5A");
    send_byte(CHAR_ESC);
    check_frame("escape");
    report_and_finish();
  end

  // ----------------------------------------
  // Frame checker
  // ----------------------------------------

  // Outputs settle after the rising edge
  always @(negedge clk) begin
    if (rst) begin
      prev_hs      = 1'b0;
      prev_vs      = 1'b0;
      prev_de      = 1'b0;
      armed        = 1'b0;
      had_fall     = 1'b0;
      pix_idx      = 0;
      line_pix     = 0;
      lines        = 0;
      hs_rises     = 0;
      hs_len       = 0;
      vs_len       = 0;
      frame_cycles = 0;
    end else begin
      frame_cycles++;
      if (hsync) begin
        hs_len++;
      end
      if (vsync) begin
        vs_len++;
      end
      if (hsync && !prev_hs) begin
        hs_rises++;
      end
      if (!hsync && prev_hs) begin
        check_eq("hsync width", SYNC_LEN, hs_len);
        hs_len = 0;
      end
      if (de) begin
        if (armed) begin
          check_eq($sformatf("%s pixel x=%0d y=%0d", test_name,
                             pix_idx % H_VIS, pix_idx / H_VIS),
                   int'(ref_pixel(pix_idx % H_VIS, pix_idx / H_VIS)), int'(pixel));
          pix_idx++;
        end
        line_pix++;
      end else begin
        // Blanking keeps the pixel dark
        check_eq($sformatf("%s pixel in blanking", test_name), 0, int'(pixel));
      end
      if (!de && prev_de) begin
        if (armed) begin
          check_eq("de pixels per line", H_VIS, line_pix);
          // Sync pulse starts right where de ends
          check_eq("hsync rise at de fall", 1, int'(hsync && !prev_hs));
          lines++;
        end
        line_pix = 0;
      end
      // Fall of vsync opens a frame
      if (!vsync && prev_vs) begin
        check_eq("vsync width", SYNC_LEN * H_TOTAL, vs_len);
        if (had_fall) begin
          check_eq("hsync pulses per frame", V_TOTAL, hs_rises);
          check_eq("clocks per frame", H_TOTAL * V_TOTAL, frame_cycles);
        end
        vs_len       = 0;
        hs_rises     = 0;
        frame_cycles = 0;
        pix_idx      = 0;
        lines        = 0;
        armed        = 1'b1;
        had_fall     = 1'b1;
      end
      // Rise of vsync closes the visible part
      if (vsync && !prev_vs && armed) begin
        check_eq("de pixels per frame", H_VIS * V_VIS, pix_idx);
        check_eq("de lines per frame", V_VIS, lines);
        armed = 1'b0;
        frames_done++;
      end
      prev_hs = hsync;
      prev_vs = vsync;
      prev_de = de;
    end
  end

endmodule

`default_nettype wire

// File: logic/text_term.sv
`timescale 1ns/1ns
`default_nettype none

module text_term #(
  parameter int NUM_ROWS = term_geom_pkg::DEF_NUM_ROWS,
  parameter int NUM_COLS = term_geom_pkg::DEF_NUM_COLS,
  parameter int H_BLANK  = term_geom_pkg::DEF_H_BLANK,
  parameter int V_BLANK  = term_geom_pkg::DEF_V_BLANK,
  parameter int SYNC_LEN = term_geom_pkg::DEF_SYNC_LEN
) (
  input  logic                 clk,
  input  logic                 rst,
  input  term_char_pkg::char_t ascii,
  input  logic                 ascii_val,
  output logic                 hsync,
  output logic                 vsync,
  output logic                 de,
  output logic                 pixel
);
  import term_geom_pkg::*;
  import term_char_pkg::*;

  store_wr_t wr_req;
  cursor_t   cur;
  scan_pos_t pos;
  char_t     rd_code;
  scan_pos_t rd_pos;
  logic      rd_cursor;

  // ----------------------------------------
  // Write side and raster side
  // ----------------------------------------

  cursor_ctrl #(
    .NUM_ROWS (NUM_ROWS),
    .NUM_COLS (NUM_COLS)
  ) u_cursor_ctrl (
    .clk       (clk),
    .rst       (rst),
    .ascii     (ascii),
    .ascii_val (ascii_val),
    .wr_req    (wr_req),
    .cur       (cur)
  );

  scan_timing #(
    .NUM_ROWS (NUM_ROWS),
    .NUM_COLS (NUM_COLS),
    .H_BLANK  (H_BLANK),
    .V_BLANK  (V_BLANK),
    .SYNC_LEN (SYNC_LEN)
  ) u_scan_timing (
    .clk (clk),
    .rst (rst),
    .pos (pos)
  );

  // ----------------------------------------
  // Memory read, then pixel stage
  // ----------------------------------------

  char_store #(
    .NUM_ROWS (NUM_ROWS),
    .NUM_COLS (NUM_COLS)
  ) u_char_store (
    .clk       (clk),
    .rst       (rst),
    .wr_req    (wr_req),
    .cur       (cur),
    .pos       (pos),
    .rd_code   (rd_code),
    .rd_pos    (rd_pos),
    .rd_cursor (rd_cursor)
  );

  pixel_compose u_pixel_compose (
    .clk       (clk),
    .rst       (rst),
    .rd_code   (rd_code),
    .rd_pos    (rd_pos),
    .rd_cursor (rd_cursor),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de),
    .pixel     (pixel)
  );

endmodule

`default_nettype wire

// File: logic/pixel_compose.sv
`timescale 1ns/1ns
`default_nettype none

`include "glyph_table.svh"

module pixel_compose (
  input  logic                     clk,
  input  logic                     rst,
  input  term_char_pkg::char_t     rd_code,
  input  term_geom_pkg::scan_pos_t rd_pos,
  input  logic                     rd_cursor,
  output logic                     hsync,
  output logic                     vsync,
  output logic                     de,
  output logic                     pixel
);
  import term_geom_pkg::*;

  logic [7:0] glyph_bits;
  cell_off_t  bit_idx;
  logic       underline;
  logic       lit;

  // ----------------------------------------
  // Glyph lookup
  // ----------------------------------------

  assign glyph_bits = glyph_row(rd_code, rd_pos.voff);

  // hoff 0 is the leftmost pixel, bit 7
  assign bit_idx = 3'd7 - rd_pos.hoff;

  // Bottom cell row, last pixel column left dark
  assign underline = rd_cursor && (rd_pos.voff == 3'd7) && (rd_pos.hoff != 3'd7);

  // Blanking, then cursor, then glyph
  always_comb begin
    if (!rd_pos.active) begin
      lit = 1'b0;
    end else if (underline) begin
      lit = 1'b1;
    end else begin
      lit = glyph_bits[bit_idx];
    end
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------

  // Syncs and de take the same stage as the pixel
  always_ff @(posedge clk) begin
    if (rst) begin
      pixel <= 1'b0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      de    <= 1'b0;
    end else begin
      pixel <= lit;
      hsync <= rd_pos.hsync;
      vsync <= rd_pos.vsync;
      de    <= rd_pos.active;
    end
  end

endmodule

`default_nettype wire

// File: logic/char_store.sv
`timescale 1ns/1ns
`default_nettype none

module char_store #(
  parameter int NUM_ROWS = term_geom_pkg::DEF_NUM_ROWS,
  parameter int NUM_COLS = term_geom_pkg::DEF_NUM_COLS
) (
  input  logic                     clk,
  input  logic                     rst,
  input  term_char_pkg::store_wr_t wr_req,
  input  term_char_pkg::cursor_t   cur,
  input  term_geom_pkg::scan_pos_t pos,
  output term_char_pkg::char_t     rd_code,
  output term_geom_pkg::scan_pos_t rd_pos,
  output logic                     rd_cursor
);
  import term_geom_pkg::*;
  import term_char_pkg::*;

  // Index widths sized to the array, never zero
  localparam int RW = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1;
  localparam int CW = (NUM_COLS > 1) ? $clog2(NUM_COLS) : 1;

  char_t                 mem [NUM_ROWS][NUM_COLS];
  logic [$bits(row_t):0] row_sum;
  row_t                  phys_row;
  logic                  in_range;
  logic [RW-1:0]         rd_row;
  logic [CW-1:0]         rd_col;
  logic                  hit;

  // ----------------------------------------
  // Write and clear side
  // ----------------------------------------

  for (genvar i = 0; i < NUM_ROWS; i++) begin : g_row
    always_ff @(posedge clk) begin
      if (rst || wr_req.clr_all) begin
        mem[i] <= '{default: '0};
      end else if (wr_req.clr_row && (wr_req.clr_idx == row_t'(i))) begin
        // Clear beats a write to the same row
        mem[i] <= '{default: '0};
      end else if (wr_req.wr && (wr_req.row == row_t'(i))) begin
        mem[i][wr_req.col[CW-1:0]] <= wr_req.code;
      end
    end
  end

  // ----------------------------------------
  // Read side through the scroll offset
  // ----------------------------------------

  assign in_range = (int'(pos.row) < NUM_ROWS) && (int'(pos.col) < NUM_COLS);

  // Display row plus top, modulo NUM_ROWS
  assign row_sum  = {1'b0, pos.row} + {1'b0, cur.top};
  assign phys_row = (int'(row_sum) >= NUM_ROWS) ? row_t'(int'(row_sum) - NUM_ROWS)
                                                : row_t'(row_sum);

  // Blanking positions read cell 0, pixel is masked later anyway
  assign rd_row = in_range ? phys_row[RW-1:0] : '0;
  assign rd_col = in_range ? pos.col[CW-1:0] : '0;

  assign hit = in_range && (phys_row == cur.row) && (pos.col == cur.col);

  always_ff @(posedge clk) begin
    rd_code <= mem[rd_row][rd_col];
  end

  // Position and cursor flag travel with the code
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pos    <= '0;
      rd_cursor <= 1'b0;
    end else begin
      rd_pos    <= pos;
      rd_cursor <= hit;
    end
  end

  a_wr_col: assert property (@(posedge clk) disable iff (rst)
    wr_req.wr |-> (int'(wr_req.col) < NUM_COLS));

endmodule

`default_nettype wire

// File: logic/scan_timing.sv
`timescale 1ns/1ns
`default_nettype none

module scan_timing #(
  parameter int NUM_ROWS = term_geom_pkg::DEF_NUM_ROWS,
  parameter int NUM_COLS = term_geom_pkg::DEF_NUM_COLS,
  parameter int H_BLANK  = term_geom_pkg::DEF_H_BLANK,
  parameter int V_BLANK  = term_geom_pkg::DEF_V_BLANK,
  parameter int SYNC_LEN = term_geom_pkg::DEF_SYNC_LEN
) (
  input  logic                     clk,
  input  logic                     rst,
  output term_geom_pkg::scan_pos_t pos
);
  import term_geom_pkg::*;

  // Visible area in pixels, then full line and frame
  localparam int H_VIS   = NUM_COLS * 8;
  localparam int V_VIS   = NUM_ROWS * 8;
  localparam int H_TOTAL = H_VIS + H_BLANK;
  localparam int V_TOTAL = V_VIS + V_BLANK;
  localparam int HW      = $clog2(H_TOTAL);
  localparam int VW      = $clog2(V_TOTAL);

  logic [HW-1:0] h_cnt;
  logic [VW-1:0] v_cnt;
  logic          h_last;
  logic          v_last;

  assign h_last = (h_cnt == HW'(H_TOTAL - 1));
  assign v_last = (v_cnt == VW'(V_TOTAL - 1));

  // One pixel per clk, line count steps at end of line
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      h_cnt <= h_last ? '0 : h_cnt + 1'b1;
      if (h_last) begin
        v_cnt <= v_last ? '0 : v_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Cell split and sync levels
  // ----------------------------------------

  always_comb begin
    pos        = '0;
    pos.col    = col_t'(h_cnt >> 3);
    pos.hoff   = h_cnt[2:0];
    pos.row    = row_t'(v_cnt >> 3);
    pos.voff   = v_cnt[2:0];
    pos.active = (int'(h_cnt) < H_VIS) && (int'(v_cnt) < V_VIS);
    // Pulses open the blanking interval
    pos.hsync  = (int'(h_cnt) >= H_VIS) && (int'(h_cnt) < H_VIS + SYNC_LEN);
    pos.vsync  = (int'(v_cnt) >= V_VIS) && (int'(v_cnt) < V_VIS + SYNC_LEN);
  end

  a_sync_blank: assert property (@(posedge clk) disable iff (rst)
    pos.hsync |-> !pos.active);

endmodule

`default_nettype wire

// File: logic/cursor_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cursor_ctrl #(
  parameter int NUM_ROWS = term_geom_pkg::DEF_NUM_ROWS,
  parameter int NUM_COLS = term_geom_pkg::DEF_NUM_COLS
) (
  input  logic                     clk,
  input  logic                     rst,
  input  term_char_pkg::char_t     ascii,
  input  logic                     ascii_val,
  output term_char_pkg::store_wr_t wr_req,
  output term_char_pkg::cursor_t   cur
);
  import term_geom_pkg::*;
  import term_char_pkg::*;

  localparam row_t LAST_ROW = row_t'(NUM_ROWS - 1);
  localparam col_t LAST_COL = col_t'(NUM_COLS - 1);
  // Bottom display line holds the cursor row
  localparam row_t TOP_INIT = row_t'(1 % NUM_ROWS);

  logic is_esc;
  logic is_del;
  logic is_lf;
  logic is_print;
  logic new_line;
  row_t row_q;
  row_t row_d;
  row_t row_inc;
  col_t col_q;
  col_t col_d;
  row_t top_q;
  row_t top_d;
  row_t top_inc;

  // ----------------------------------------
  // Byte decode
  // ----------------------------------------

  assign is_esc   = ascii_val && (ascii == CHAR_ESC);
  assign is_del   = ascii_val && (ascii == CHAR_DEL);
  assign is_lf    = ascii_val && (ascii == CHAR_LF);
  assign is_print = ascii_val && !is_esc && !is_del && !is_lf;

  // Row and scroll wrap at NUM_ROWS
  assign row_inc = (row_q == LAST_ROW) ? '0 : row_q + 1'b1;
  assign top_inc = (top_q == LAST_ROW) ? '0 : top_q + 1'b1;

  // LF, or a printable byte in the last column
  assign new_line = is_lf || (is_print && (col_q == LAST_COL));

  // ----------------------------------------
  // Cursor next state
  // ----------------------------------------

  always_comb begin
    row_d = row_q;
    col_d = col_q;
    top_d = top_q;
    if (is_esc) begin
      row_d = '0;
      col_d = '0;
      top_d = TOP_INIT;
    end else if (is_del) begin
      // Stays put at column 0
      if (col_q != '0) begin
        col_d = col_q - 1'b1;
      end
    end else if (new_line) begin
      row_d = row_inc;
      col_d = '0;
      top_d = top_inc;
    end else if (is_print) begin
      col_d = col_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      row_q <= '0;
      col_q <= '0;
      top_q <= TOP_INIT;
    end else begin
      row_q <= row_d;
      col_q <= col_d;
      top_q <= top_d;
    end
  end

  assign cur = '{row: row_q, col: col_q, top: top_q};

  // ----------------------------------------
  // Buffer requests
  // ----------------------------------------

  always_comb begin
    wr_req         = '0;
    wr_req.clr_all = is_esc;
    // Row being entered gets wiped
    wr_req.clr_row = new_line;
    wr_req.clr_idx = row_inc;
    wr_req.wr      = is_print || is_del;
    wr_req.code    = is_del ? char_t'(0) : ascii;
    wr_req.row     = row_q;
    // DEL erases the cell it steps back onto
    wr_req.col     = is_del ? col_d : col_q;
  end

  a_cur_bounds: assert property (@(posedge clk) disable iff (rst)
    (int'(cur.row) < NUM_ROWS) && (int'(cur.col) < NUM_COLS));

endmodule

`default_nettype wire

// File: logic/term_char_pkg.sv
`default_nettype none

package term_char_pkg;

  // ASCII code, 0 marks an empty cell
  typedef logic [7:0] char_t;

  // Control codes taken from the stream
  localparam char_t CHAR_ESC = 8'h1B;
  localparam char_t CHAR_DEL = 8'h7F;
  localparam char_t CHAR_LF  = 8'h0A;

  // One buffer update, applied at the next edge
  typedef struct packed {
    logic                wr;
    char_t               code;
    term_geom_pkg::row_t row;
    term_geom_pkg::col_t col;
    logic                clr_all;
    logic                clr_row;
    term_geom_pkg::row_t clr_idx;
  } store_wr_t;

  // Cursor position plus the scroll offset
  typedef struct packed {
    term_geom_pkg::row_t row;
    term_geom_pkg::col_t col;
    term_geom_pkg::row_t top;
  } cursor_t;

endpackage

`default_nettype wire

// File: logic/term_geom_pkg.sv
`default_nettype none

package term_geom_pkg;

  // ----------------------------------------
  // Character grid and cell indices
  // ----------------------------------------

  // Up to 32 text rows
  typedef logic [4:0] row_t;
  // Up to 128 text columns
  typedef logic [6:0] col_t;
  // Pixel offset inside an 8x8 cell
  typedef logic [2:0] cell_off_t;

  // Raster position as seen by the read side
  typedef struct packed {
    col_t      col;
    row_t      row;
    cell_off_t hoff;
    cell_off_t voff;
    logic      active;
    logic      hsync;
    logic      vsync;
  } scan_pos_t;

  // ----------------------------------------
  // Default geometry, forwarded by the top
  // ----------------------------------------

  localparam int DEF_NUM_ROWS = 4;
  localparam int DEF_NUM_COLS = 8;
  localparam int DEF_H_BLANK  = 16;
  localparam int DEF_V_BLANK  = 8;
  localparam int DEF_SYNC_LEN = 4;

endpackage

`default_nettype wire

// File: include/glyph_table.svh
`ifndef GLYPH_TABLE_SVH
`define GLYPH_TABLE_SVH

// 8x8 font, first cell row in the top byte
// Bit 7 of each row is the leftmost pixel
function automatic logic [7:0] glyph_row(
  input term_char_pkg::char_t     code,
  input term_geom_pkg::cell_off_t roff
);
  logic [63:0] rows;
  case (code)
    // Empty cell and space
    8'h00, 8'h20: rows = 64'h0000_0000_0000_0000;
    // Digits 0 to 9
    8'h30: rows = 64'h3C66_6E76_6666_3C00;
    8'h31: rows = 64'h1838_1818_1818_7E00;
    8'h32: rows = 64'h3C66_060C_3060_7E00;
    8'h33: rows = 64'h3C66_061C_0666_3C00;
    8'h34: rows = 64'h0C1C_3C6C_7E0C_0C00;
    8'h35: rows = 64'h7E60_7C06_0666_3C00;
    8'h36: rows = 64'h3C60_7C66_6666_3C00;
    8'h37: rows = 64'h7E06_0C18_3030_3000;
    8'h38: rows = 64'h3C66_663C_6666_3C00;
    8'h39: rows = 64'h3C66_663E_060C_3800;
    // Upper case A to F only
    8'h41: rows = 64'h183C_6666_7E66_6600;
    8'h42: rows = 64'h7C66_667C_6666_7C00;
    8'h43: rows = 64'h3C66_6060_6066_3C00;
    8'h44: rows = 64'h786C_6666_666C_7800;
    8'h45: rows = 64'h7E60_607C_6060_7E00;
    8'h46: rows = 64'h7E60_607C_6060_6000;
    // Anything else shows a hollow box
    default: rows = 64'h7E42_4242_4242_7E00;
  endcase
  // Row 7 stays clear so the cursor underline stands out
  return rows[8 * (7 - roff) +: 8];
endfunction

`endif
